// File: source/loopPkg.sv
`default_nettype none

package loopPkg;

    // ====================
    // Datapath widths
    // ====================
    localparam int errorWidth = 16;  // Signed phase error.
    localparam int outWidth   = 32;  // Integrator, limit, preload and output.

    // Gain is mantissa * 2^-exp applied to the conditioned error.
    typedef struct packed {
        logic [4:0] exp;  // Right shift amount.
        logic [7:0] man;  // Unsigned multiplier.
    } gainT;

    // Packed so that zeroError lands on bit 0 of the control register.
    typedef struct packed {
        logic clearAccum;   // Load integrator with preload.
        logic holdAccum;    // Freeze integrator.
        logic invertError;  // Negate the error.
        logic zeroError;    // Force the error to zero.
    } loopCtrlT;

    // ====================
    // Data words
    // ====================
    typedef logic signed [errorWidth-1:0] errorT;
    typedef logic signed [outWidth-1:0]   loopWordT;

endpackage

`default_nettype wire

// File: source/regMapPkg.sv
`default_nettype none

package regMapPkg;

    // Host bus.
    localparam int addrWidth = 13;
    localparam int dataWidth = 32;
    localparam int laneCount = dataWidth / 8;  // One write enable per byte lane.

    // ====================
    // Register map
    // ====================
    localparam logic [addrWidth-1:0] addrControl      = 13'd0;
    localparam logic [addrWidth-1:0] addrLeadLag0     = 13'd1;
    localparam logic [addrWidth-1:0] addrLimit        = 13'd2;
    localparam logic [addrWidth-1:0] addrLoopData0    = 13'd3;
    localparam logic [addrWidth-1:0] addrLeadLag1     = 13'd4;
    localparam logic [addrWidth-1:0] addrLoopData1    = 13'd5;
    localparam logic [addrWidth-1:0] addrLockDetector = 13'd6;
    localparam logic [addrWidth-1:0] addrIntegrator   = 13'd7;  // Read only.

    // Bits outside these masks read as zero.
    localparam logic [dataWidth-1:0] ctrlMask    = 32'h0000_000F;
    localparam logic [dataWidth-1:0] leadLagMask = 32'hFF1F_FF1F;
    localparam logic [dataWidth-1:0] lockMask    = 32'h0FFF_FFFF;

endpackage

`default_nettype wire

// File: source/loopCfgIf.sv
`timescale 1ns/1ns
`default_nettype none

// One loop's configuration, from the register bank to a filter.
interface loopCfgIf import loopPkg::*;
    ;

    loopCtrlT ctrl;     // Shared control bits.
    gainT     lead;     // Proportional path gain.
    gainT     lag;      // Integral path gain.
    loopWordT limit;    // Symmetric saturation bound.
    loopWordT preload;  // Integrator load value.

    modport source (
        output ctrl,
        output lead,
        output lag,
        output limit,
        output preload
    );

    modport sink (
        input ctrl,
        input lead,
        input lag,
        input limit,
        input preload
    );

endinterface

`default_nettype wire

// File: source/loopRegs.sv
`timescale 1ns/1ns
`default_nettype none

module loopRegs import loopPkg::*, regMapPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [addrWidth-1:0] addr,
    input  logic [dataWidth-1:0] dataIn,
    output logic [dataWidth-1:0] dataOut,
    input  logic                 cs,
    input  logic [3:0]           wr,
    input  logic                 lockStatus,
    input  loopWordT             lagAccum,
    loopCfgIf.source             cfg0,
    loopCfgIf.source             cfg1,
    output logic [15:0]          lockCount,
    output logic [11:0]          syncThreshold
);

    logic [dataWidth-1:0] ctrlReg;
    logic [dataWidth-1:0] leadLag0Reg;
    logic [dataWidth-1:0] limitReg;
    logic [dataWidth-1:0] loopData0Reg;
    logic [dataWidth-1:0] leadLag1Reg;
    logic [dataWidth-1:0] loopData1Reg;
    logic [dataWidth-1:0] lockReg;

    // Replace the enabled byte lanes, then drop unimplemented bits.
    function automatic logic [dataWidth-1:0] mergeLanes(
        input logic [dataWidth-1:0] current,
        input logic [dataWidth-1:0] mask
    );
        logic [dataWidth-1:0] merged;
        merged = current;
        for (int lane = 0; lane < laneCount; lane++) begin
            if (wr[lane]) begin
                merged[lane*8 +: 8] = dataIn[lane*8 +: 8];
            end
        end
        return merged & mask;
    endfunction

    // Half of a lead-lag word holds the exponent in the low lane and the mantissa in the high lane.
    function automatic gainT gainField(input logic [15:0] half);
        return '{exp: half[4:0], man: half[15:8]};
    endfunction

    // ====================
    // Register writes
    // ====================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlReg      <= '0;
            leadLag0Reg  <= '0;
            limitReg     <= '0;
            loopData0Reg <= '0;
            leadLag1Reg  <= '0;
            loopData1Reg <= '0;
            lockReg      <= '0;
        end else if (cs && (wr != '0)) begin
            case (addr)
                addrControl:      ctrlReg      <= mergeLanes(ctrlReg, ctrlMask);
                addrLeadLag0:     leadLag0Reg  <= mergeLanes(leadLag0Reg, leadLagMask);
                addrLimit:        limitReg     <= mergeLanes(limitReg, '1);
                addrLoopData0:    loopData0Reg <= mergeLanes(loopData0Reg, '1);
                addrLeadLag1:     leadLag1Reg  <= mergeLanes(leadLag1Reg, leadLagMask);
                addrLoopData1:    loopData1Reg <= mergeLanes(loopData1Reg, '1);
                addrLockDetector: lockReg      <= mergeLanes(lockReg, lockMask);
                default: ;  // Integrator and unmapped addresses ignore writes.
            endcase
        end
    end

    // ====================
    // Configuration fan-out
    // ====================
    assign cfg0.ctrl    = loopCtrlT'(ctrlReg[$bits(loopCtrlT)-1:0]);
    assign cfg0.lag     = gainField(leadLag0Reg[15:0]);
    assign cfg0.lead    = gainField(leadLag0Reg[31:16]);
    assign cfg0.limit   = limitReg;
    assign cfg0.preload = loopData0Reg;

    assign cfg1.ctrl    = loopCtrlT'(ctrlReg[$bits(loopCtrlT)-1:0]);  // Same control word.
    assign cfg1.lag     = gainField(leadLag1Reg[15:0]);
    assign cfg1.lead    = gainField(leadLag1Reg[31:16]);
    assign cfg1.limit   = limitReg;
    assign cfg1.preload = loopData1Reg;

    assign lockCount     = lockReg[15:0];
    assign syncThreshold = lockReg[27:16];

    // Readback is zero when deselected or unmapped.
    always_comb begin
        dataOut = '0;
        if (cs) begin
            case (addr)
                addrControl:      dataOut = {lockStatus, ctrlReg[dataWidth-2:0]};
                addrLeadLag0:     dataOut = leadLag0Reg;
                addrLimit:        dataOut = limitReg;
                addrLoopData0:    dataOut = loopData0Reg;
                addrLeadLag1:     dataOut = leadLag1Reg;
                addrLoopData1:    dataOut = loopData1Reg;
                addrLockDetector: dataOut = lockReg;
                addrIntegrator:   dataOut = lagAccum;  // Live loop 0 integrator.
                default:          dataOut = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/loopFilter.sv
`timescale 1ns/1ns
`default_nettype none

module loopFilter import loopPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    loopCfgIf.sink   cfg,
    input  errorT    error,
    input  logic     errorValid,
    output loopWordT loopOut,
    output logic     loopValid,
    output loopWordT lagAccum
);

    logic signed [errorWidth:0]   condError;  // One extra bit so negation cannot wrap.
    loopWordT                     lagTerm;
    loopWordT                     leadTerm;
    logic signed [outWidth+1:0]   accumSum;
    logic signed [outWidth+1:0]   outSum;
    loopWordT                     nextAccum;

    // Error times mantissa, arithmetic shift right by exponent.
    function automatic loopWordT scaleTerm(
        input logic signed [errorWidth:0] e,
        input gainT                       g
    );
        logic signed [errorWidth+9:0] product;
        loopWordT                     extended;
        product  = e * $signed({1'b0, g.man});
        extended = product;  // Sign extended.
        return extended >>> g.exp;
    endfunction

    // Clamp a wide sum to +/- lim.
    function automatic loopWordT saturate(
        input logic signed [outWidth+1:0] value,
        input loopWordT                   lim
    );
        logic signed [outWidth+1:0] hi;
        logic signed [outWidth+1:0] lo;
        logic signed [outWidth+1:0] result;
        hi     = lim;
        lo     = -hi;
        result = value;
        if (value > hi) begin
            result = hi;
        end else if (value < lo) begin
            result = lo;
        end
        return loopWordT'(result);
    endfunction

    // ====================
    // Error conditioning
    // ====================
    always_comb begin
        condError = {error[errorWidth-1], error};
        if (cfg.ctrl.invertError) begin
            condError = -condError;
        end
        if (cfg.ctrl.zeroError) begin
            condError = '0;  // Zero wins over invert.
        end
    end

    assign lagTerm  = scaleTerm(condError, cfg.lag);
    assign leadTerm = scaleTerm(condError, cfg.lead);
    assign accumSum = lagAccum + lagTerm;

    // Integrator priority is clear, then hold, then accumulate.
    always_comb begin
        if (cfg.ctrl.clearAccum) begin
            nextAccum = cfg.preload;
        end else if (cfg.ctrl.holdAccum) begin
            nextAccum = lagAccum;
        end else begin
            nextAccum = saturate(accumSum, cfg.limit);
        end
    end

    assign outSum = nextAccum + leadTerm;  // Lead acts on the updated integrator.

    // ====================
    // Registers
    // ====================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lagAccum  <= '0;
            loopValid <= 1'b0;
        end else begin
            loopValid <= errorValid;
            if (errorValid) begin
                lagAccum <= nextAccum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (errorValid) begin
            loopOut <= saturate(outSum, cfg.limit);
        end
    end

endmodule

`default_nettype wire

// File: source/lockDetector.sv
`timescale 1ns/1ns
`default_nettype none

module lockDetector import loopPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  errorT       error,
    input  logic        errorValid,
    input  logic [15:0] lockCount,
    input  logic [11:0] syncThreshold,
    output logic        lockStatus
);

    logic [errorWidth:0] absError;  // Wide enough for the most negative error.
    logic [15:0]         runCount;
    logic [15:0]         nextCount;
    logic                smallError;

    assign absError   = error[errorWidth-1] ? -{1'b1, error} : {1'b0, error};
    assign smallError = absError < {5'b0, syncThreshold};

    // Run of consecutive small errors, saturating at full scale.
    always_comb begin
        if (!smallError) begin
            nextCount = '0;
        end else if (runCount == '1) begin
            nextCount = runCount;
        end else begin
            nextCount = runCount + 16'd1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            runCount   <= '0;
            lockStatus <= 1'b0;
        end else if (errorValid) begin
            runCount   <= nextCount;
            lockStatus <= (lockCount != '0) && (nextCount >= lockCount);  // Zero count disables.
        end
    end

endmodule

`default_nettype wire

// File: source/loopTop.sv
`timescale 1ns/1ns
`default_nettype none

module loopTop import loopPkg::*, regMapPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [addrWidth-1:0] addr,
    input  logic [dataWidth-1:0] dataIn,
    output logic [dataWidth-1:0] dataOut,
    input  logic                 cs,
    input  logic [3:0]           wr,
    input  errorT                error0,
    input  errorT                error1,
    input  logic                 errorValid,
    output loopWordT             loopOut0,
    output loopWordT             loopOut1,
    output logic                 loopValid,
    output logic                 lockStatus
);

    logic [15:0] lockCount;
    logic [11:0] syncThreshold;
    loopWordT    lagAccum0;

    loopCfgIf cfg0 ();
    loopCfgIf cfg1 ();

    loopRegs i_regs (
        .clk, .rstN, .addr, .dataIn, .dataOut, .cs, .wr,
        .lockStatus,
        .lagAccum (lagAccum0),
        .cfg0     (cfg0.source),
        .cfg1     (cfg1.source),
        .lockCount,
        .syncThreshold
    );

    // Both loops share errorValid, so their outputs stay aligned.
    loopFilter i_loop0 (
        .clk, .rstN,
        .cfg        (cfg0.sink),
        .error      (error0),
        .errorValid,
        .loopOut    (loopOut0),
        .loopValid,
        .lagAccum   (lagAccum0)
    );

    loopFilter i_loop1 (
        .clk, .rstN,
        .cfg        (cfg1.sink),
        .error      (error1),
        .errorValid,
        .loopOut    (loopOut1),
        .loopValid  (),
        .lagAccum   ()
    );

    lockDetector i_lock (
        .clk, .rstN,
        .error      (error0),  // Lock follows loop 0 only.
        .errorValid,
        .lockCount,
        .syncThreshold,
        .lockStatus
    );

endmodule

`default_nettype wire

// File: tests/loopTb.sv
`timescale 1ns/1ns
`default_nettype none

module loopTb import loopPkg::*, regMapPkg::*;
    ();

    localparam int period      = 40;
    localparam int numWrites   = 150;
    localparam int gainSets    = 4;
    localparam int stepsPerSet = 50;
    localparam int testCycles  = numWrites * 5 + gainSets * (stepsPerSet + 8) + 500;

    logic                 clk;
    logic                 rstN;
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] dataIn;
    logic [dataWidth-1:0] dataOut;
    logic                 cs;
    logic [3:0]           wr;
    errorT                error0;
    errorT                error1;
    logic                 errorValid;
    loopWordT             loopOut0;
    loopWordT             loopOut1;
    logic                 loopValid;
    logic                 lockStatus;

    // Reference model state.
    logic [dataWidth-1:0] mirror [0:6];  // Writable registers at addresses 0 to 6.
    longint               acc0;
    longint               acc1;
    logic [15:0]          runCount;
    logic                 expLock;
    loopWordT             expOut0;
    loopWordT             expOut1;
    int                   checkCount;
    int                   errorCount;

    loopTop i_dut (
        .clk, .rstN, .addr, .dataIn, .dataOut, .cs, .wr,
        .error0, .error1, .errorValid,
        .loopOut0, .loopOut1, .loopValid, .lockStatus
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        #(longint'(testCycles + 100) * period);
        $display("Timeout, the tests did not finish within %0d cycles", testCycles + 100);
        $display("Regression failed");
        $finish;
    end

    // ====================
    // Compare tasks
    // ====================
    task automatic checkWord(input string name, input logic [dataWidth-1:0] got,
                             input logic [dataWidth-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkLoop(input string name, input loopWordT got, input loopWordT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkLock(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // ====================
    // Reference model
    // ====================
    function automatic logic [dataWidth-1:0] maskOf(input logic [addrWidth-1:0] a);
        case (a)
            addrControl:                return 32'h0000_000F;  // Four control bits.
            addrLeadLag0, addrLeadLag1: return 32'hFF1F_FF1F;
            addrLockDetector:           return 32'h0FFF_FFFF;
            default:                    return 32'hFFFF_FFFF;
        endcase
    endfunction

    function automatic logic [dataWidth-1:0] expectedRead(input logic [addrWidth-1:0] a);
        if (a == addrControl) begin
            return {expLock, mirror[a][30:0]};  // Live lock bit on top.
        end
        if (a == addrIntegrator) begin
            return dataWidth'(acc0);
        end
        if (a < addrIntegrator) begin
            return mirror[a];
        end
        return '0;
    endfunction

    function automatic longint condition(input errorT e);
        longint v;
        v = e;
        if (mirror[addrControl][1]) begin
            v = -v;
        end
        if (mirror[addrControl][0]) begin
            v = 0;
        end
        return v;
    endfunction

    // Gain half word has the exponent in bits 4:0 and the mantissa in bits 15:8.
    function automatic longint scaled(input longint e, input logic [15:0] gain);
        longint product;
        product = e * longint'(gain[15:8]);
        return product >>> gain[4:0];
    endfunction

    function automatic longint clamp(input longint v, input longint lim);
        if (v > lim) begin
            return lim;
        end
        if (v < -lim) begin
            return -lim;
        end
        return v;
    endfunction

    task automatic filterStep(input errorT e, input logic [dataWidth-1:0] gains,
                              input logic [dataWidth-1:0] preload, inout longint acc,
                              output loopWordT out);
        longint ce;
        longint lim;
        longint nextAcc;
        ce  = condition(e);
        lim = longint'($signed(mirror[addrLimit]));
        if (mirror[addrControl][3]) begin
            nextAcc = longint'($signed(preload));
        end else if (mirror[addrControl][2]) begin
            nextAcc = acc;
        end else begin
            nextAcc = clamp(acc + scaled(ce, gains[15:0]), lim);
        end
        acc = nextAcc;
        out = loopWordT'(clamp(nextAcc + scaled(ce, gains[31:16]), lim));
    endtask

    task automatic lockStep(input errorT e);
        int          mag;
        logic [15:0] target;
        mag    = int'(e);
        target = mirror[addrLockDetector][15:0];
        if (mag < 0) begin
            mag = -mag;
        end
        if (mag >= int'(mirror[addrLockDetector][27:16])) begin
            runCount = '0;
        end else if (runCount != 16'hFFFF) begin
            runCount++;  // Saturates at full scale.
        end
        expLock = (target != '0) && (runCount >= target);
    endtask

    // ====================
    // Stimulus
    // ====================
    task automatic busWrite(input logic [addrWidth-1:0] a, input logic [dataWidth-1:0] d,
                            input logic [3:0] lanes);
        @(negedge clk);
        addr   = a;
        dataIn = d;
        wr     = lanes;
        cs     = 1'b1;
        @(negedge clk);
        cs = 1'b0;
        wr = 4'h0;
        if (a < addrIntegrator) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (lanes[lane]) begin
                    mirror[a][lane*8 +: 8] = d[lane*8 +: 8];
                end
            end
            mirror[a] = mirror[a] & maskOf(a);
        end
    endtask

    task automatic busRead(input logic [addrWidth-1:0] a, input logic sel);
        @(negedge clk);
        addr = a;
        cs   = sel;
        wr   = 4'h0;
        #(period / 4);  // Quarter period into the low phase.
        checkWord($sformatf("dataOut[%0d]", a), dataOut, sel ? expectedRead(a) : '0);
        checkFlag("loopValid", loopValid, 1'b0);
    endtask

    function automatic errorT randError(input int bound);
        int r;
        r = int'($urandom % (2 * bound + 1)) - bound;
        return errorT'(r);
    endfunction

    task automatic checkOutputs();
        checkFlag("loopValid", loopValid, 1'b1);
        checkLoop("loopOut0", loopOut0, expOut0);
        checkLoop("loopOut1", loopOut1, expOut1);
        checkLock("lockStatus", lockStatus, expLock);
    endtask

    // Back-to-back error strobes with each result checked one cycle later.
    task automatic runErrors(input int count, input int bound0, input int bound1);
        errorT e0;
        errorT e1;
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            if (i > 0) begin
                checkOutputs();
            end
            e0         = randError(bound0);
            e1         = randError(bound1);
            error0     = e0;
            error1     = e1;
            errorValid = 1'b1;
            filterStep(e0, mirror[addrLeadLag0], mirror[addrLoopData0], acc0, expOut0);
            filterStep(e1, mirror[addrLeadLag1], mirror[addrLoopData1], acc1, expOut1);
            lockStep(e0);
        end
        @(negedge clk);
        checkOutputs();
        errorValid = 1'b0;
    endtask

    initial begin
        logic [addrWidth-1:0] a;
        void'($urandom(32'h5a65));
        rstN       = 1'b0;
        addr       = '0;
        dataIn     = '0;
        cs         = 1'b0;
        wr         = 4'h0;
        error0     = '0;
        error1     = '0;
        errorValid = 1'b0;
        for (int i = 0; i < 7; i++) begin
            mirror[i] = '0;
        end
        acc0       = 0;
        acc1       = 0;
        runCount   = '0;
        expLock    = 1'b0;
        expOut0    = '0;
        expOut1    = '0;
        checkCount = 0;
        errorCount = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        checkFlag("loopValid", loopValid, 1'b0);
        checkLock("lockStatus", lockStatus, 1'b0);
        for (int i = 0; i < 8; i++) begin
            busRead(addrWidth'(i), 1'b1);
        end

        // ==================== Register bank
        repeat (numWrites) begin
            a = addrWidth'($urandom % 10);  // Includes read-only and unmapped targets.
            busWrite(a, $urandom, 4'($urandom));
            busRead(a, 1'b1);
            busRead(addrWidth'(8 + $urandom % 8000), 1'b1);
            busRead(addrWidth'($urandom % 8), 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            busRead(addrWidth'(i), 1'b1);
        end

        // ==================== Lead-lag with a large limit
        busWrite(addrControl, 32'h0, 4'hF);
        busWrite(addrLimit, 32'h4000_0000, 4'hF);
        repeat (gainSets) begin
            busWrite(addrLeadLag0, $urandom, 4'hF);
            busWrite(addrLeadLag1, $urandom, 4'hF);
            runErrors(stepsPerSet, 32768, 32768);
            busRead(addrIntegrator, 1'b1);
        end

        // Small limit and strong gains drive both loops into saturation.
        busWrite(addrLimit, 32'd1 + $urandom % 4000, 4'hF);
        busWrite(addrLeadLag0, ($urandom & 32'hFF03_FF03) | 32'h8000_8000, 4'hF);
        busWrite(addrLeadLag1, ($urandom & 32'hFF03_FF03) | 32'h8000_8000, 4'hF);
        runErrors(40, 32768, 32768);
        busRead(addrIntegrator, 1'b1);

        // ==================== Control bits
        busWrite(addrLimit, 32'h7FFF_0000, 4'hF);
        busWrite(addrLoopData0, $urandom, 4'hF);
        busWrite(addrLoopData1, $urandom, 4'hF);
        busWrite(addrControl, 32'h8, 4'h1);  // Clear to preload.
        runErrors(3, 32768, 32768);
        busRead(addrIntegrator, 1'b1);
        busWrite(addrControl, 32'h4, 4'h1);  // Hold.
        runErrors(10, 32768, 32768);
        busRead(addrIntegrator, 1'b1);
        busWrite(addrLoopData0, $urandom, 4'hF);
        busWrite(addrLoopData1, $urandom, 4'hF);
        busWrite(addrControl, 32'hC, 4'h1);  // Clear wins over hold.
        runErrors(3, 32768, 32768);
        busRead(addrIntegrator, 1'b1);
        busWrite(addrControl, 32'h2, 4'h1);
        runErrors(10, 32768, 32768);
        busWrite(addrControl, 32'h1, 4'h1);
        runErrors(10, 32768, 32768);
        busWrite(addrControl, 32'h3, 4'h1);  // Zero beats invert.
        runErrors(10, 32768, 32768);
        busWrite(addrControl, 32'h0, 4'h1);

        // ==================== Lock detector
        busWrite(addrLockDetector, {4'h0, 12'd100, 16'd5}, 4'hF);
        repeat (8) begin
            runErrors(1 + $urandom % 9, 99, 32768);
            busRead(addrControl, 1'b1);
            runErrors(1, 32768, 32768);
            busRead(addrControl, 1'b1);
        end
        busWrite(addrLockDetector, 32'h0, 4'h3);  // Lock count of zero disables lock.
        runErrors(8, 99, 32768);
        busRead(addrControl, 1'b1);

        $display("Checks run %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
source/loopPkg.sv
source/regMapPkg.sv
source/loopCfgIf.sv
source/loopRegs.sv
source/loopFilter.sv
source/lockDetector.sv
source/loopTop.sv
tests/loopTb.sv

// File: Makefile
TOP := loopTb

.PHONY: all lint clean

all:
	verilator --binary -Wno-fatal --top-module $(TOP) -f project.f --Mdir obj_dir -o simv
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir
